/* rtl/dagPkg.sv */
package dagPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Basic types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [13:0] addrT;   // I, M, L and addresses. M is two's complement.
  typedef logic [1:0]  setIdT;  // Selects one register set.
  typedef logic [1:0]  chanT;   // Serial-port autobuffer channel.
  typedef logic [3:0]  wrapVecT; // One wrap bit per channel with chanT as the index.

  typedef enum logic [2:0] {
    OpWriteI,
    OpWriteM,
    OpWriteL,
    OpReadI,
    OpPostModify
  } dagOpT;

  localparam chanT ChanT0 = 2'd0;  // Transmit channel 0.
  localparam chanT ChanT1 = 2'd1;  // Transmit channel 1.
  localparam chanT ChanR0 = 2'd2;  // Receive channel 0.
  localparam chanT ChanR1 = 2'd3;  // Receive channel 1.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pipeline payloads
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    dagOpT op;
    setIdT setId;
    addrT  data;     // Value for the three write operations.
    logic  autoBuf;  // Post-modify issued on behalf of the autobuffer.
    chanT  chan;
  } dagCmdT;

  typedef struct packed {
    dagOpT op;
    setIdT setId;
    logic  autoBuf;
    chanT  chan;
    addrT  indexReg;
    addrT  modifyReg;
    addrT  lengthReg;
  } dagOperandT;

  typedef struct packed {
    dagOpT op;
    setIdT setId;
    logic  autoBuf;
    chanT  chan;
    addrT  oldIndex;
    addrT  newIndex;
    logic  wrapped;
  } dagExecT;

  typedef struct packed {
    addrT    address;
    wrapVecT wrapFlags;
  } dagRspT;

endpackage

/* rtl/moduloAdder.sv */
`timescale 1ns/1ps

module moduloAdder (
  input  logic               DSPCLK,
  input  logic               rst,
  input  logic               advance,
  input  logic               opValid,
  input  dagPkg::dagOperandT operand,
  output logic               exValid,
  output dagPkg::dagExecT    exec,
  output logic               exBusy,
  output dagPkg::setIdT      exSet
);

  dagPkg::addrT idx;
  dagPkg::addrT mod;
  dagPkg::addrT len;

  assign idx = operand.indexReg;
  assign mod = operand.modifyReg;
  assign len = operand.lengthReg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Buffer masks from L
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  dagPkg::addrT leadMask;   // Ones from the leading one of L downward.
  dagPkg::addrT trailMask;  // Ones from the trailing one of L upward.
  dagPkg::addrT baseMask;   // Bits of I that form the buffer base.
  dagPkg::addrT offMask;    // Bits of I that form the offset in the buffer.
  logic         notPow2;
  logic         lenZero;

  always_comb
  begin
    leadMask = '0;
    for (int b = 13; b >= 0; b--)
    begin
      if (len[b])
      begin
        leadMask = dagPkg::addrT'((15'd1 << (b + 1)) - 15'd1);
        break;
      end
    end
  end

  assign trailMask = len | (~len + 14'd1);  // Two's complement keeps the trailing one.
  assign notPow2   = (len & (len - 14'd1)) != '0;
  assign lenZero   = (len == '0);

  // A power of two uses its own bit as the buffer size; anything else rounds
  // up to the next power above the leading one.
  assign baseMask = notPow2 ? ~leadMask : trailMask;
  assign offMask  = ~baseMask;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sums and selection
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [14:0]  offExt;    // Zero-extended offset.
  logic [14:0]  modExt;    // Sign-extended M.
  logic [14:0]  lenTerm;   // +L or the ones' complement of L.
  logic [14:0]  sumM;      // Offset plus M.
  logic [14:0]  sumML;     // Offset plus M corrected by L.
  logic         modNeg;
  dagPkg::addrT newOffset;
  dagPkg::addrT newIndex;
  logic         wrapped;

  assign modNeg  = mod[13];
  assign offExt  = {1'b0, idx & offMask};
  assign modExt  = {mod[13], mod};
  assign lenTerm = modNeg ? {1'b0, len} : {1'b1, ~len};

  assign sumM  = offExt + modExt;
  // The carry-in completes the subtraction of L when M is not negative.
  assign sumML = offExt + modExt + lenTerm + {14'd0, ~modNeg};

  // Going down, a negative sum means the pointer left the bottom. Going up,
  // a non-negative corrected sum means it reached the top.
  always_comb
  begin
    if (modNeg)
    begin
      newOffset = sumM[14] ? sumML[13:0] : sumM[13:0];
    end
    else
    begin
      newOffset = sumML[14] ? sumM[13:0] : sumML[13:0];
    end
  end

  assign newIndex = (idx & baseMask) | newOffset;  // With L zero the base is empty.
  assign wrapped  = !lenZero && (modNeg ? sumM[14] : !sumML[14]);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Execute register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge DSPCLK)
  begin
    if (rst)
    begin
      exValid <= 1'b0;
    end
    else if (advance)
    begin
      exValid <= opValid;
    end
  end

  always_ff @(posedge DSPCLK)
  begin
    if (advance)
    begin
      exec.op       <= operand.op;
      exec.setId    <= operand.setId;
      exec.autoBuf  <= operand.autoBuf;
      exec.chan     <= operand.chan;
      exec.oldIndex <= idx;
      exec.newIndex <= newIndex;
      exec.wrapped  <= wrapped;
    end
  end

  assign exBusy = exValid && (exec.op == dagPkg::OpPostModify);  // Pending write-back.
  assign exSet  = exec.setId;

endmodule

/* rtl/dagDecode.sv */
`timescale 1ns/1ps

module dagDecode #(
  parameter int NumSets = 4
) (
  input  logic               DSPCLK,
  input  logic               rst,
  input  logic               cmdValid,
  input  dagPkg::dagCmdT     cmd,
  output logic               cmdReady,
  input  logic               advance,
  input  logic               wbValid,
  input  dagPkg::setIdT      wbSet,
  input  dagPkg::addrT       wbIndex,
  input  logic               exBusy,
  input  dagPkg::setIdT      exSet,
  output logic               opValid,
  output dagPkg::dagOperandT operand
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register bank
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  dagPkg::addrT indexRegs  [NumSets];
  dagPkg::addrT modifyRegs [NumSets];
  dagPkg::addrT lengthRegs [NumSets];

  logic         accept;
  logic         opBusy;
  logic         hazard;
  dagPkg::addrT readIndex;

  // A post-modify sitting in the operand register will write I back later.
  assign opBusy = opValid && (operand.op == dagPkg::OpPostModify);

  // Any command on a set with an unfinished post-modify must wait, since
  // it would see the stale I or have its own write overwritten.
  assign hazard = (opBusy && (operand.setId == cmd.setId)) ||
                  (exBusy && (exSet == cmd.setId));

  assign cmdReady = advance && !hazard;  // Whole pipe stalls on back-pressure.
  assign accept   = cmdValid && cmdReady;

  // The result stage writes back in the same cycle, so forward its value.
  assign readIndex = (wbValid && (wbSet == cmd.setId)) ? wbIndex
                                                      : indexRegs[cmd.setId];

  always_ff @(posedge DSPCLK)
  begin
    if (rst)
    begin
      for (int i = 0; i < NumSets; i++)
      begin
        indexRegs[i]  <= '0;
        modifyRegs[i] <= '0;
        lengthRegs[i] <= '0;
      end
    end
    else
    begin
      if (wbValid)
      begin
        indexRegs[wbSet] <= wbIndex;  // New I from an earlier post-modify.
      end
      if (accept)
      begin
        // The younger command comes last, so its write wins a collision.
        case (cmd.op)
          dagPkg::OpWriteI: indexRegs[cmd.setId]  <= cmd.data;
          dagPkg::OpWriteM: modifyRegs[cmd.setId] <= cmd.data;
          dagPkg::OpWriteL: lengthRegs[cmd.setId] <= cmd.data;
          default: ;
        endcase
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Operand register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge DSPCLK)
  begin
    if (rst)
    begin
      opValid <= 1'b0;
    end
    else if (advance)
    begin
      opValid <= accept;  // A bubble enters when nothing is accepted.
    end
  end

  always_ff @(posedge DSPCLK)
  begin
    if (advance)
    begin
      operand.op        <= cmd.op;
      operand.setId     <= cmd.setId;
      operand.autoBuf   <= cmd.autoBuf;
      operand.chan      <= cmd.chan;
      operand.modifyReg <= modifyRegs[cmd.setId];
      operand.lengthReg <= lengthRegs[cmd.setId];
      // For a write the response returns the written data, which rides
      // down the pipe in the index slot.
      if ((cmd.op == dagPkg::OpWriteI) || (cmd.op == dagPkg::OpWriteM) ||
          (cmd.op == dagPkg::OpWriteL))
      begin
        operand.indexReg <= cmd.data;
      end
      else
      begin
        operand.indexReg <= readIndex;
      end
    end
  end

endmodule

/* rtl/dagResult.sv */
`timescale 1ns/1ps

module dagResult (
  input  logic            DSPCLK,
  input  logic            rst,
  input  logic            exValid,
  input  dagPkg::dagExecT exec,
  input  logic            rspReady,
  output logic            rspValid,
  output dagPkg::dagRspT  rsp,
  output logic            advance,
  output logic            wbValid,
  output dagPkg::setIdT   wbSet,
  output dagPkg::addrT    wbIndex
);

  logic             isPostModify;
  logic             pmHeld;  // The held response belongs to a post-modify.
  dagPkg::wrapVecT  wrapFlags;

  assign isPostModify = (exec.op == dagPkg::OpPostModify);

  // Only an autobuffer post-modify that crossed the buffer end raises a flag.
  always_comb
  begin
    wrapFlags = '0;
    if (isPostModify && exec.autoBuf && exec.wrapped)
    begin
      wrapFlags[exec.chan] = 1'b1;
    end
  end

  // The whole pipe moves unless a response is stuck at the output.
  assign advance = !(rspValid && !rspReady);

  always_ff @(posedge DSPCLK)
  begin
    if (rst)
    begin
      rspValid <= 1'b0;
      rsp      <= '0;
      pmHeld   <= 1'b0;
    end
    else if (advance)
    begin
      rspValid      <= exValid;
      rsp.address   <= exec.oldIndex;
      rsp.wrapFlags <= exValid ? wrapFlags : '0;
      pmHeld        <= exValid && isPostModify;
    end
  end

  always_ff @(posedge DSPCLK)
  begin
    if (advance)
    begin
      wbSet   <= exec.setId;
      wbIndex <= exec.newIndex;
    end
  end

  // I is updated in the bank exactly when the response is taken.
  assign wbValid = rspValid && rspReady && pmHeld;

endmodule

/* rtl/dagTop.sv */
`timescale 1ns/1ps

module dagTop #(
  parameter int NumSets = 4
) (
  input  logic           DSPCLK,
  input  logic           rst,
  input  logic           cmdValid,
  input  dagPkg::dagCmdT cmd,
  output logic           cmdReady,
  output logic           rspValid,
  output dagPkg::dagRspT rsp,
  input  logic           rspReady
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage links
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic               advance;
  logic               opValid;
  dagPkg::dagOperandT operand;
  logic               exValid;
  dagPkg::dagExecT    exec;
  logic               exBusy;
  dagPkg::setIdT      exSet;
  logic               wbValid;
  dagPkg::setIdT      wbSet;
  dagPkg::addrT       wbIndex;

  dagDecode #(
    .NumSets (NumSets)
  ) decode (
    .DSPCLK   (DSPCLK),
    .rst      (rst),
    .cmdValid (cmdValid),
    .cmd      (cmd),
    .cmdReady (cmdReady),
    .advance  (advance),
    .wbValid  (wbValid),
    .wbSet    (wbSet),
    .wbIndex  (wbIndex),
    .exBusy   (exBusy),
    .exSet    (exSet),
    .opValid  (opValid),
    .operand  (operand)
  );

  moduloAdder execute (
    .DSPCLK  (DSPCLK),
    .rst     (rst),
    .advance (advance),
    .opValid (opValid),
    .operand (operand),
    .exValid (exValid),
    .exec    (exec),
    .exBusy  (exBusy),
    .exSet   (exSet)
  );

  dagResult result (
    .DSPCLK   (DSPCLK),
    .rst      (rst),
    .exValid  (exValid),
    .exec     (exec),
    .rspReady (rspReady),
    .rspValid (rspValid),
    .rsp      (rsp),
    .advance  (advance),
    .wbValid  (wbValid),
    .wbSet    (wbSet),
    .wbIndex  (wbIndex)
  );

endmodule

/* test/dagTb.sv */
`timescale 1ns/1ps

module dagTb;

  localparam int          MaxLines = 64;        // Room for this many stimulus lines.
  localparam int          Fields   = 7;         // Words per stimulus line.
  localparam logic [15:0] EndMark  = 16'hFFFF;  // Opcode word that ends the list.

  logic           DSPCLK;
  logic           rst;
  logic           cmdValid;
  dagPkg::dagCmdT cmd;
  logic           cmdReady;
  logic           rspValid;
  dagPkg::dagRspT rsp;
  logic           rspReady;

  logic [15:0]    stimMem [0:MaxLines*Fields-1];
  dagPkg::dagRspT expQ [$];  // Expected responses of accepted commands with the oldest first.
  logic [31:0]    lcgState;
  int             numLines;
  int             sent;
  int             received;
  int             cycles;
  int             cycleLimit;

  dagTop #(
    .NumSets (4)
  ) dut (
    .DSPCLK   (DSPCLK),
    .rst      (rst),
    .cmdValid (cmdValid),
    .cmd      (cmd),
    .cmdReady (cmdReady),
    .rspValid (rspValid),
    .rsp      (rsp),
    .rspReady (rspReady)
  );

  initial
  begin
    DSPCLK = 1'b0;
    forever #4 DSPCLK = ~DSPCLK;  // 8 ns period.
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic loadCommand(input int line);
    int base;
    base        = line * Fields;
    cmd.op      = dagPkg::dagOpT'(stimMem[base][2:0]);
    cmd.setId   = stimMem[base + 1][1:0];
    cmd.data    = stimMem[base + 2][13:0];
    cmd.autoBuf = stimMem[base + 3][0];
    cmd.chan    = stimMem[base + 4][1:0];
  endtask

  function automatic dagPkg::dagRspT expectedResponse(input int line);
    dagPkg::dagRspT expected;
    expected.address   = stimMem[line * Fields + 5][13:0];
    expected.wrapFlags = stimMem[line * Fields + 6][3:0];
    return expected;
  endfunction

  task automatic stopWithFailure();
    $display("Regression failed");
    $fatal(1, "Stopped at the first failure.");
  endtask

  task automatic checkResponse(input dagPkg::dagRspT seen);
    dagPkg::dagRspT expected;
    if (expQ.size() == 0)
    begin
      $display("A response arrived at %0t with no command outstanding.", $time);
      stopWithFailure();
    end
    else
    begin
      expected = expQ.pop_front();
      assert (seen.address == expected.address)
      else
      begin
        $display("Error at %0t: rsp.address expected %h, got %h", $time,
                 expected.address, seen.address);
        stopWithFailure();
      end
      assert (seen.wrapFlags == expected.wrapFlags)
      else
      begin
        $display("Error at %0t: rsp.wrapFlags expected %b, got %b", $time,
                 expected.wrapFlags, seen.wrapFlags);
        stopWithFailure();
      end
      received++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus and scoreboard
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial
  begin
    logic           cmdFire;
    logic           rspFire;
    dagPkg::dagRspT rspSeen;
    rst      = 1'b1;
    cmdValid = 1'b0;
    cmd      = '0;
    rspReady = 1'b0;
    lcgState = 32'd48;
    numLines = 0;
    sent     = 0;
    received = 0;
    cycles   = 0;
    $readmemh("test/dagStim.txt", stimMem);
    while ((numLines < MaxLines) && (stimMem[numLines * Fields] != EndMark))
      numLines++;
    cycleLimit = 20 * numLines + 50;
    repeat (3) @(posedge DSPCLK);
    @(negedge DSPCLK);
    assert (cmdReady && !rspValid)
    else
    begin
      $display("Handshake outputs are wrong at the end of reset.");
      stopWithFailure();
    end
    rst = 1'b0;
    if (numLines > 0)
    begin
      cmdValid = 1'b1;
      loadCommand(0);
    end
    while (received < numLines)
    begin
      @(posedge DSPCLK);
      cmdFire = cmdValid && cmdReady;  // Values seen by the DUT at this edge.
      rspFire = rspValid && rspReady;
      rspSeen = rsp;
      cycles++;
      @(negedge DSPCLK);
      if (cycles > cycleLimit)
      begin
        $display("Timeout after %0d cycles with %0d of %0d responses.", cycles,
                 received, numLines);
        stopWithFailure();
      end
      if (cmdFire)
      begin
        expQ.push_back(expectedResponse(sent));
        sent++;
        if (sent < numLines)
        begin
          loadCommand(sent);
        end
        else
        begin
          cmdValid = 1'b0;
          cmd      = '0;
        end
      end
      if (rspFire)
      begin
        checkResponse(rspSeen);
      end
      lcgState = lcgNext(lcgState);
      rspReady = (lcgState[31:30] != 2'b00);  // Low on about a quarter of cycles.
    end
    // Every command is answered, so the three stages must drain without output.
    repeat (4)
    begin
      @(posedge DSPCLK);
      assert (!rspValid)
      else
      begin
        $display("An extra response appeared at %0t after the last one.", $time);
        stopWithFailure();
      end
    end
    $display("Regression passed");
    $finish;
  end

endmodule

/* list.f */
rtl/dagPkg.sv
rtl/moduloAdder.sv
rtl/dagDecode.sv
rtl/dagResult.sv
rtl/dagTop.sv
test/dagTb.sv

/* run.sh */
#!/bin/sh
# Build the DAG testbench with Verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dagTb -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build did not complete."
  exit 1
fi

output=$(./obj_dir/VdagTb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status."
  exit 1
fi

# The run counts as good only when the testbench printed its pass line.
if printf '%s\n' "$output" | grep -qx "Regression passed"; then
  exit 0
else
  echo "Pass line not found in the simulation output."
  exit 1
fi

/* test/dagStim.txt */
// Columns in hex: op set data autoBuf chan expectedAddress expectedWrapFlags.
// Ops: 0 write I, 1 write M, 2 write L, 3 read I, 4 post-modify. A lone ffff ends the list.
0 0 3ffe 0 0 3ffe 0
1 0 0001 0 0 0001 0
2 0 0000 0 0 0000 0
3 0 0000 0 0 3ffe 0
4 0 0000 1 0 3ffe 0
4 0 0000 1 0 3fff 0
4 0 0000 1 0 0000 0
0 1 0105 0 0 0105 0
1 1 0003 0 0 0003 0
2 1 0008 0 0 0008 0
3 1 0000 0 0 0105 0
4 1 0000 1 1 0105 2
4 1 0000 1 1 0100 0
4 1 0000 1 1 0103 0
4 1 0000 0 1 0106 0
3 1 0000 0 0 0101 0
0 2 0203 0 0 0203 0
1 2 0002 0 0 0002 0
2 2 0005 0 0 0005 0
0 3 0301 0 0 0301 0
1 3 3ffd 0 0 3ffd 0
2 3 0006 0 0 0006 0
3 2 0000 0 0 0203 0
3 3 0000 0 0 0301 0
4 2 0000 1 2 0203 4
4 3 0000 1 0 0301 1
4 2 0000 1 2 0200 0
4 3 0000 1 0 0304 0
4 2 0000 1 3 0202 0
4 2 0000 1 3 0204 8
4 3 0000 1 0 0301 1
3 2 0000 0 0 0201 0
3 3 0000 0 0 0304 0
ffff
